/* axi_pkg.sv */
package axi_pkg;

  // AXI burst encodings.
  typedef enum logic [1:0] {
    FIXED = 2'b00,
    INCR  = 2'b01,
    WRAP  = 2'b10
  } axi_burst_t;

  // Beats in the burst minus one.
  typedef logic [7:0] axi_len_t;

  // Log2 of bytes per beat.
  typedef logic [2:0] axi_size_t;

  // Bytes moved by one beat of the given size.
  function automatic logic [7:0] beat_bytes(axi_size_t size);
    return 8'd1 << size;
  endfunction

endpackage

/* b2s_beat_if.sv */
`timescale 1ns/10ps

interface b2s_beat_if;

  import b2s_pkg::*;

  // Id and last flag of the beat being requested.
  beat_tag_t tag;
  // Tag write strobe.
  logic      push;
  // Room left in the beat buffer.
  logic      data_ready;

  modport cmd (
    output tag,
    output push,
    input  data_ready
  );

  modport rdata (
    input  tag,
    input  push,
    output data_ready
  );

endinterface

/* b2s_cmd_translator.sv */
`timescale 1ns/10ps

`include "b2s_config.svh"

module b2s_cmd_translator (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   a_push,
  input  logic                   s_arvalid,
  input  logic [`ADDR_WIDTH-1:0] s_araddr,
  input  logic [`ID_WIDTH-1:0]   s_arid,
  input  axi_pkg::axi_len_t      s_arlen,
  input  axi_pkg::axi_size_t     s_arsize,
  input  axi_pkg::axi_burst_t    s_arburst,
  input  logic                   next,
  output logic                   next_pending,
  output logic [`ADDR_WIDTH-1:0] m_araddr,
  output logic [`ID_WIDTH-1:0]   m_arid,
  b2s_beat_if.cmd                beat
);

  import axi_pkg::*;

  localparam int AW = `ADDR_WIDTH;

  logic [AW-1:0]        addr_r;
  logic [AW-1:0]        addr_step;
  logic [`ID_WIDTH-1:0] id_r;
  axi_size_t            size_r;
  axi_burst_t           burst_r;
  axi_len_t             beats_left;
  logic                 load;

  assign load = a_push && s_arvalid;

  // WRAP steps like INCR.
  assign addr_step = (burst_r == FIXED) ? '0 : AW'(beat_bytes(size_r));

  always_ff @(posedge clk) begin
    if (reset) begin
      beats_left <= '0;
      burst_r    <= INCR;
    end else if (load) begin
      beats_left <= s_arlen;
      burst_r    <= s_arburst;
    end else if (next && next_pending) begin
      beats_left <= beats_left - 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      addr_r <= s_araddr;
      id_r   <= s_arid;
      size_r <= s_arsize;
    end else if (next) begin
      addr_r <= addr_r + addr_step;
    end
  end

  assign next_pending = (beats_left != '0);

  assign m_araddr = addr_r;
  assign m_arid   = id_r;

  // Tag for the beat now on the master AR channel.
  assign beat.tag = '{id: id_r, last: !next_pending};

endmodule

/* b2s_config.svh */
`ifndef B2S_CONFIG_SVH
`define B2S_CONFIG_SVH

// AXI id width.
`define ID_WIDTH 4

// Address width on both sides.
`define ADDR_WIDTH 32

// Read data width on slave and master.
`define DATA_WIDTH 32

// Entries in the beat tag and read data FIFOs.
`define BEAT_FIFO_DEPTH 8

`endif

/* b2s_pkg.sv */
`include "b2s_config.svh"

package b2s_pkg;

  // Read command FSM states.
  typedef enum logic [1:0] {
    IDLE         = 2'b00,
    CMD_EN       = 2'b01,
    CMD_ACCEPTED = 2'b10,
    DONE         = 2'b11
  } cmd_state_t;

  // Per-beat tag, queued when the master request is accepted.
  typedef struct packed {
    logic [`ID_WIDTH-1:0] id;
    logic                 last;
  } beat_tag_t;

endpackage

/* b2s_r_chan.sv */
`timescale 1ns/10ps

`include "b2s_config.svh"

module b2s_r_chan (
  input  logic                   clk,
  input  logic                   reset,
  b2s_beat_if.rdata              beat,
  input  logic                   m_rvalid,
  output logic                   m_rready,
  input  logic [`DATA_WIDTH-1:0] m_rdata,
  output logic                   s_rvalid,
  input  logic                   s_rready,
  output logic [`DATA_WIDTH-1:0] s_rdata,
  output logic [`ID_WIDTH-1:0]   s_rid,
  output logic                   s_rlast
);

  import b2s_pkg::*;

  localparam int TAG_W = $bits(beat_tag_t);

  beat_tag_t tag_head;
  logic      tag_empty;
  logic      tag_almost_full;
  logic      data_push;
  logic      data_empty;
  logic      data_full;
  logic      pop;

  assign data_push = m_rvalid && m_rready;
  assign pop       = s_rvalid && s_rready;

  sync_fifo #(
    .WIDTH (TAG_W),
    .DEPTH (`BEAT_FIFO_DEPTH)
  ) tag_fifo (
    .clk         (clk),
    .reset       (reset),
    .wr_en       (beat.push),
    .wr_data     (beat.tag),
    .rd_en       (pop),
    .rd_data     (tag_head),
    .full        (),
    .empty       (tag_empty),
    .almost_full (tag_almost_full)
  );

  sync_fifo #(
    .WIDTH (`DATA_WIDTH),
    .DEPTH (`BEAT_FIFO_DEPTH)
  ) data_fifo (
    .clk         (clk),
    .reset       (reset),
    .wr_en       (data_push),
    .wr_data     (m_rdata),
    .rd_en       (pop),
    .rd_data     (s_rdata),
    .full        (data_full),
    .empty       (data_empty),
    .almost_full ()
  );

  assign m_rready = !data_full;

  // A beat is ready once its data has arrived behind its tag.
  assign s_rvalid = !tag_empty && !data_empty;
  assign s_rid    = tag_head.id;
  assign s_rlast  = tag_head.last;

  // Tag FIFO never holds fewer entries than the data FIFO.
  assign beat.data_ready = !tag_almost_full;

endmodule

/* b2s_rd_asserts.sv */
`timescale 1ns/10ps

`include "b2s_config.svh"

module b2s_rd_asserts (
  input logic                   clk,
  input logic                   reset,
  input logic                   s_arvalid,
  input logic                   s_arready,
  input axi_pkg::axi_len_t      s_arlen,
  input logic                   m_arvalid,
  input logic                   m_arready,
  input logic [`ADDR_WIDTH-1:0] m_araddr,
  input logic                   m_rvalid,
  input logic                   m_rready,
  input logic                   s_rvalid,
  input logic                   s_rready,
  input logic [`DATA_WIDTH-1:0] s_rdata,
  input logic [`ID_WIDTH-1:0]   s_rid,
  input logic                   s_rlast
);

  import axi_pkg::*;

  int       fail_count = 0;
  logic     cmd_seen;
  axi_len_t req_count;

  // Master requests accepted so far in the current burst.
  always_ff @(posedge clk) begin
    if (reset) begin
      cmd_seen  <= 1'b0;
      req_count <= '0;
    end else begin
      cmd_seen <= cmd_seen || s_arvalid;
      if (s_arready) begin
        req_count <= '0;
      end else if (m_arvalid && m_arready) begin
        req_count <= req_count + 1'b1;
      end
    end
  end

  // Quiet outputs until the first command.
  assert property (@(posedge clk) disable iff (reset)
      !cmd_seen |-> !s_arready && !m_arvalid && !s_rvalid)
    else begin
      fail_count++;
      $error("Output active before the first slave command.");
    end

  // One release per burst on the final master request.
  assert property (@(posedge clk) disable iff (reset)
      s_arready |-> (m_arvalid && m_arready && req_count == s_arlen) ##1 !s_arready)
    else begin
      fail_count++;
      $error("s_arready not a single pulse on the last master request.");
    end

  assert property (@(posedge clk) disable iff (reset)
      m_arvalid && !m_arready |=> m_arvalid && $stable(m_araddr))
    else begin
      fail_count++;
      $error("Master AR request changed before it was accepted.");
    end

  // Requests never outrun the data buffer.
  assert property (@(posedge clk) disable iff (reset)
      m_rvalid |-> m_rready)
    else begin
      fail_count++;
      $error("Master R data offered while the data FIFO was full.");
    end

  assert property (@(posedge clk) disable iff (reset)
      s_rvalid && !s_rready |=> s_rvalid && $stable({s_rdata, s_rid, s_rlast}))
    else begin
      fail_count++;
      $error("Slave R beat changed before it was taken.");
    end

endmodule

bind b2s_rd_top b2s_rd_asserts u_asserts (.*);

/* b2s_rd_cmd_fsm.sv */
`timescale 1ns/10ps

module b2s_rd_cmd_fsm (
  input  logic    clk,
  input  logic    reset,
  input  logic    s_arvalid,
  output logic    s_arready,
  output logic    m_arvalid,
  input  logic    m_arready,
  output logic    next,
  input  logic    next_pending,
  output logic    a_push,
  b2s_beat_if.cmd beat
);

  import b2s_pkg::*;

  cmd_state_t state;
  cmd_state_t next_state;
  logic       data_ready;

  assign data_ready = beat.data_ready;

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= IDLE;
    end else begin
      state <= next_state;
    end
  end

  always_comb begin
    next_state = state;
    case (state)
      IDLE: begin
        if (s_arvalid && data_ready) begin
          next_state = CMD_EN;
        end
      end
      CMD_EN: begin
        if (m_arready && !next_pending) begin
          next_state = DONE;
        end else if (m_arready && !data_ready) begin
          // Buffer is filling, so hold off further requests.
          next_state = CMD_ACCEPTED;
        end
      end
      CMD_ACCEPTED: begin
        if (data_ready) begin
          next_state = CMD_EN;
        end
      end
      DONE: begin
        next_state = IDLE;
      end
      default: begin
        next_state = IDLE;
      end
    endcase
  end

  assign m_arvalid = (state == CMD_EN);
  assign next      = m_arready && (state == CMD_EN);
  assign a_push    = (state == IDLE);

  // Slave command is released with the last master request.
  assign s_arready = next && !next_pending;

  // One tag per accepted master request.
  assign beat.push = next;

endmodule

/* b2s_rd_top.sv */
`timescale 1ns/10ps

`include "b2s_config.svh"

module b2s_rd_top (
  input  logic                   clk,
  input  logic                   reset,
  input  logic [`ID_WIDTH-1:0]   s_arid,
  input  logic [`ADDR_WIDTH-1:0] s_araddr,
  input  axi_pkg::axi_len_t      s_arlen,
  input  axi_pkg::axi_size_t     s_arsize,
  input  axi_pkg::axi_burst_t    s_arburst,
  input  logic                   s_arvalid,
  output logic                   s_arready,
  output logic [`ID_WIDTH-1:0]   s_rid,
  output logic [`DATA_WIDTH-1:0] s_rdata,
  output logic                   s_rlast,
  output logic                   s_rvalid,
  input  logic                   s_rready,
  output logic [`ID_WIDTH-1:0]   m_arid,
  output logic [`ADDR_WIDTH-1:0] m_araddr,
  output axi_pkg::axi_len_t      m_arlen,
  output logic                   m_arvalid,
  input  logic                   m_arready,
  input  logic [`DATA_WIDTH-1:0] m_rdata,
  input  logic                   m_rvalid,
  output logic                   m_rready
);

  logic a_push;
  logic next;
  logic next_pending;

  b2s_beat_if beat ();

  // Every master request is a single beat.
  assign m_arlen = '0;

  b2s_rd_cmd_fsm u_cmd_fsm (
    .clk          (clk),
    .reset        (reset),
    .s_arvalid    (s_arvalid),
    .s_arready    (s_arready),
    .m_arvalid    (m_arvalid),
    .m_arready    (m_arready),
    .next         (next),
    .next_pending (next_pending),
    .a_push       (a_push),
    .beat         (beat.cmd)
  );

  b2s_cmd_translator u_cmd_translator (
    .clk          (clk),
    .reset        (reset),
    .a_push       (a_push),
    .s_arvalid    (s_arvalid),
    .s_araddr     (s_araddr),
    .s_arid       (s_arid),
    .s_arlen      (s_arlen),
    .s_arsize     (s_arsize),
    .s_arburst    (s_arburst),
    .next         (next),
    .next_pending (next_pending),
    .m_araddr     (m_araddr),
    .m_arid       (m_arid),
    .beat         (beat.cmd)
  );

  b2s_r_chan u_r_chan (
    .clk      (clk),
    .reset    (reset),
    .beat     (beat.rdata),
    .m_rvalid (m_rvalid),
    .m_rready (m_rready),
    .m_rdata  (m_rdata),
    .s_rvalid (s_rvalid),
    .s_rready (s_rready),
    .s_rdata  (s_rdata),
    .s_rid    (s_rid),
    .s_rlast  (s_rlast)
  );

endmodule

/* project.f */
+incdir+.
axi_pkg.sv
b2s_pkg.sv
b2s_beat_if.sv
sync_fifo.sv
b2s_rd_cmd_fsm.sv
b2s_cmd_translator.sv
b2s_r_chan.sv
b2s_rd_top.sv
b2s_rd_asserts.sv
tb_b2s_rd.sv

/* sync_fifo.sv */
`timescale 1ns/10ps

module sync_fifo #(
  parameter int WIDTH = 8,
  parameter int DEPTH = 8
) (
  input  logic             clk,
  input  logic             reset,
  input  logic             wr_en,
  input  logic [WIDTH-1:0] wr_data,
  input  logic             rd_en,
  output logic [WIDTH-1:0] rd_data,
  output logic             full,
  output logic             empty,
  output logic             almost_full
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  logic [WIDTH-1:0] mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             do_wr;
  logic             do_rd;

  assign do_wr = wr_en && !full;
  assign do_rd = rd_en && !empty;

  assign full        = (count == CNT_W'(DEPTH));
  assign empty       = (count == '0);
  // High with one free slot or none.
  assign almost_full = (count >= CNT_W'(DEPTH - 1));

  // Head word is visible without a read.
  assign rd_data = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (do_wr) begin
      mem[wr_ptr] <= wr_data;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_wr) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + PTR_W'(1);
      end
      if (do_rd) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + PTR_W'(1);
      end
      case ({do_wr, do_rd})
        2'b10:   count <= count + CNT_W'(1);
        2'b01:   count <= count - CNT_W'(1);
        default: count <= count;
      endcase
    end
  end

endmodule

/* tb_b2s_rd.sv */
`timescale 1ns/10ps

`include "b2s_config.svh"

module tb_b2s_rd;

  import axi_pkg::*;

  localparam int          CLK_PERIOD = 40;
  localparam int          NUM_BURSTS = 40;
  localparam logic [31:0] DATA_KEY   = 32'h5a5a_0000;

  logic                   clk, reset;
  logic [`ID_WIDTH-1:0]   s_arid, s_rid, m_arid;
  logic [`ADDR_WIDTH-1:0] s_araddr, m_araddr;
  logic [`DATA_WIDTH-1:0] s_rdata, m_rdata;
  axi_len_t               s_arlen, m_arlen;
  axi_size_t              s_arsize;
  axi_burst_t             s_arburst;
  logic                   s_arvalid, s_arready, s_rlast, s_rvalid, s_rready;
  logic                   m_arvalid, m_arready, m_rvalid, m_rready;

  // Expected master requests, expected slave beats, and requests owed data.
  logic [31:0] ar_addr_q[$], ar_id_q[$];
  logic [31:0] r_data_q[$], r_id_q[$], r_last_q[$];
  logic [31:0] req_addr_q[$];
  integer      seed = 32'hd97b3d71;
  int          total_beats = 0;
  int          beats_seen = 0;
  int          cycle = 0;

  b2s_rd_top uut (.*);

  task automatic end_with_failure();
    $display("SOME TESTS FAILED");
    $fatal(1);
  endtask

  task automatic check_value(string name, logic [31:0] expected, logic [31:0] actual);
    assert (actual === expected) else begin
      $display("[ERROR] %s: expected %h, actual %h", name, expected, actual);
      end_with_failure();
    end
  endtask

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial begin
    #(NUM_BURSTS * 16 * 10 * CLK_PERIOD);
    $display("Timeout: the bursts did not complete in time.");
    end_with_failure();
  end

  initial begin
    wait (uut.u_asserts.fail_count != 0);
    $display("A protocol assertion in the DUT failed.");
    end_with_failure();
  end

  // Random ready stalls with long s_rready gaps that fill the beat buffer.
  initial begin
    logic [31:0] rnd;
    forever begin
      @(posedge clk);
      #1;
      cycle++;
      rnd = $random(seed);
      m_arready = (rnd[1:0] != 2'b00);
      s_rready  = (cycle % 256 < 160) && (rnd[3:2] != 2'b00);
    end
  end

  // Memory model that answers in order after 0 to 3 idle cycles.
  initial begin
    logic [31:0] rnd;
    forever begin
      @(posedge clk);
      #1;
      m_rvalid = 1'b0;
      if (req_addr_q.size() != 0) begin
        rnd = $random(seed);
        repeat (rnd[1:0]) begin
          @(posedge clk);
          #1;
        end
        m_rvalid = 1'b1;
        m_rdata  = req_addr_q.pop_front() ^ DATA_KEY;
        do @(negedge clk); while (!m_rready);
      end
    end
  end

  always @(negedge clk) begin
    if (!reset && m_arvalid && m_arready) begin
      if (ar_addr_q.size() == 0) begin
        $display("A master request appeared with no beat left to request.");
        end_with_failure();
      end else begin
        check_value("master_araddr", ar_addr_q.pop_front(), m_araddr);
        check_value("master_arid", ar_id_q.pop_front(), m_arid);
        check_value("master_arlen", 0, m_arlen);
        req_addr_q.push_back(m_araddr);
      end
    end
  end

  always @(negedge clk) begin
    if (!reset && s_rvalid && s_rready) begin
      if (r_data_q.size() == 0) begin
        $display("A slave read beat appeared with no beat expected.");
        end_with_failure();
      end else begin
        check_value("slave_rdata", r_data_q.pop_front(), s_rdata);
        check_value("slave_rid", r_id_q.pop_front(), s_rid);
        check_value("slave_rlast", r_last_q.pop_front(), s_rlast);
        beats_seen++;
      end
    end
  end

  initial begin
    logic [31:0] rnd;
    logic [31:0] addr;
    reset     = 1'b1;
    s_arid    = '0;
    s_araddr  = '0;
    s_arlen   = '0;
    s_arsize  = '0;
    s_arburst = INCR;
    s_arvalid = 1'b0;
    s_rready  = 1'b0;
    m_arready = 1'b0;
    m_rdata   = '0;
    m_rvalid  = 1'b0;
    repeat (2) @(posedge clk);
    #1;
    reset = 1'b0;
    repeat (3) @(posedge clk);
    #1;
    for (int b = 0; b < NUM_BURSTS; b++) begin
      rnd       = $random(seed);
      s_arlen   = axi_len_t'(rnd[3:0]);
      s_arid    = rnd[7:4];
      s_arburst = rnd[8] ? INCR : FIXED;
      s_arsize  = axi_size_t'(rnd[31:16] % 3);
      s_araddr  = $random(seed);
      s_araddr  = s_araddr & ~((32'd1 << s_arsize) - 1);
      // Beat addresses follow the burst rule.
      for (int i = 0; i <= s_arlen; i++) begin
        addr = (s_arburst == FIXED) ? s_araddr : s_araddr + i * (32'd1 << s_arsize);
        ar_addr_q.push_back(addr);
        ar_id_q.push_back(s_arid);
        r_data_q.push_back(addr ^ DATA_KEY);
        r_id_q.push_back(s_arid);
        r_last_q.push_back(i == s_arlen);
      end
      total_beats += s_arlen + 1;
      s_arvalid = 1'b1;
      do @(negedge clk); while (!s_arready);
      @(posedge clk);
      #1;
      s_arvalid = 1'b0;
    end
    wait (beats_seen == total_beats);
    repeat (4) @(posedge clk);
    if (ar_addr_q.size() == 0 && uut.u_asserts.fail_count == 0) begin
      $display("ALL TESTS PASSED");
      $finish;
    end else begin
      $display("Run ended with master requests left over or failed assertions.");
      end_with_failure();
    end
  end

endmodule
